/* logic/throttle_macros.svh */
// Throttle path widths, limits, scaling breakpoints and pulse timing
`ifndef THROTTLE_MACROS_SVH
`define THROTTLE_MACROS_SVH

// Data widths
`define THR_W               8
`define OPS_W               16
`define FRAME_W             16
`define APB_AW              4

// Throttle range
`define IDLE_LEVEL          10
`define MAX_LEVEL           250

// Breakpoints of the three-segment scale
`define MID_LOW             42
`define MID_HIGH            209

// Largest step of the output between two frames
`define CHANGE_LIMIT        20

// Motor pulse and frame timing, in us_clk ticks
`define MIN_PULSE_TICKS     16
`define FRAME_MIN_TICKS     272
`define FRAME_RESET_TICKS   300

`endif

/* logic/throttle_pkg.sv */
// Throttle path types: controller states, register map, APB request, config and status
`include "throttle_macros.svh"

package throttle_pkg;

	// Conditioner stages, one edge each
	typedef enum logic [2:0] {
		WAITING  = 3'd0,
		DEGLITCH = 3'd1,
		SCALE    = 3'd2,
		LIMIT    = 3'd3,
		ASSIGN   = 3'd4,
		COMPLETE = 3'd5
	} ctrl_state_e;

	// Register word addresses
	typedef enum logic [`APB_AW-1:0] {
		CTRL   = 4'd0,
		CMD    = 4'd4,
		FRAME  = 4'd8,
		STATUS = 4'd12
	} reg_addr_e;

	// APB request from the bus master
	typedef struct packed {
		logic [`APB_AW-1:0] paddr;
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [15:0]        pwdata;
	} apb_req_t;

	// Software configuration
	typedef struct packed {
		logic                cond_enable;
		logic [`THR_W-1:0]   command;
		logic [`FRAME_W-1:0] frame_ticks;
	} throttle_cfg_t;

	// Readback through STATUS
	typedef struct packed {
		logic [`THR_W-1:0] value;
		logic              busy;
		logic [7:0]        frames;
	} throttle_status_t;

endpackage

/* logic/throttle_regs.sv */
// APB register slave for throttle mode, command, frame length and status readback
`include "throttle_macros.svh"

module throttle_regs import throttle_pkg::*; (
	input  logic             us_clk,
	input  logic             resetn,
	input  apb_req_t         apb,
	output logic [15:0]      prdata,
	output logic             pready,
	output logic             pslverr,
	input  throttle_status_t status,
	output throttle_cfg_t    cfg
);

	reg_addr_e   addr;
	logic        access;
	logic        addr_ok;
	logic        frame_low;
	logic        bad_write;
	logic        wr_en;
	logic [15:0] rd_data;

	assign addr   = reg_addr_e'(apb.paddr);
	assign access = apb.psel && apb.penable;

	// No wait states on this slave
	assign pready = 1'b1;

	// Address decode and read mux
	always_comb begin
		rd_data = '0;
		addr_ok = 1'b1;
		case (addr)
			CTRL: begin
				rd_data = {15'd0, cfg.cond_enable};
			end
			CMD: begin
				rd_data = {{(16-`THR_W){1'b0}}, cfg.command};
			end
			FRAME: begin
				rd_data = cfg.frame_ticks;
			end
			STATUS: begin
				// Only the low 7 bits of the frame count fit
				rd_data = {status.frames[6:0], status.busy, status.value};
			end
			default: begin
				addr_ok = 1'b0;
			end
		endcase
	end

	assign frame_low = (addr == FRAME) && (apb.pwdata < `FRAME_MIN_TICKS);

	// STATUS is read-only, and a short frame is refused
	assign bad_write = apb.pwrite && ((addr == STATUS) || frame_low);

	assign pslverr = access && (!addr_ok || bad_write);
	assign wr_en   = access && apb.pwrite && addr_ok && !bad_write;

	assign prdata = (apb.psel && !apb.pwrite) ? rd_data : '0;

	// Writable registers, updated at the access edge
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			cfg.cond_enable <= 1'b1;
			cfg.command     <= '0;
			cfg.frame_ticks <= `FRAME_W'(`FRAME_RESET_TICKS);
		end else if (wr_en) begin
			case (addr)
				CTRL: begin
					cfg.cond_enable <= apb.pwdata[0];
				end
				CMD: begin
					cfg.command <= apb.pwdata[`THR_W-1:0];
				end
				FRAME: begin
					cfg.frame_ticks <= apb.pwdata[`FRAME_W-1:0];
				end
				default: begin
					cfg <= cfg;
				end
			endcase
		end
	end

endmodule

/* logic/throttle_controller.sv */
// Throttle conditioner FSM with clamp, de-glitch, scale, change limit and bypass
`include "throttle_macros.svh"

module throttle_controller import throttle_pkg::*; (
	input  logic              us_clk,
	input  logic              resetn,
	input  throttle_cfg_t     cfg,
	input  logic              start,
	output logic [`THR_W-1:0] throttle_out,
	output logic              active,
	output logic              complete
);

	// Offsets of the upper and middle scale segments
	localparam logic [`OPS_W-1:0] SCALE_HIGH_OFS = 252;
	localparam logic [`OPS_W-1:0] SCALE_MID_OFS  = 61;
	localparam logic [`OPS_W-1:0] STEP           = `CHANGE_LIMIT;
	localparam logic [`OPS_W-1:0] IDLE_W         = `IDLE_LEVEL;
	localparam logic [`OPS_W-1:0] MAX_W          = `MAX_LEVEL;

	ctrl_state_e state;
	ctrl_state_e next_state;

	logic [`THR_W-1:0] latched;
	logic [`THR_W-1:0] prev_latched;
	logic [`THR_W-1:0] debounced;
	logic [`THR_W-1:0] prev_out;
	logic [`OPS_W-1:0] scaled;
	logic [`OPS_W-1:0] limited;

	logic [`THR_W-1:0] clamp_cmd;
	logic              glitch;
	logic [`OPS_W-1:0] deb_w;
	logic [`OPS_W-1:0] prev_w;
	logic [`OPS_W-1:0] rise_cap;
	logic [`OPS_W-1:0] fall_val;
	logic [`OPS_W-1:0] scale_val;
	logic [`OPS_W-1:0] limit_val;

	// Clamp the command into the legal range
	always_comb begin
		if (cfg.command < `IDLE_LEVEL)
			clamp_cmd = '0;
		else if (cfg.command > `MAX_LEVEL)
			clamp_cmd = `THR_W'(`MAX_LEVEL);
		else
			clamp_cmd = cfg.command;
	end

	// Sudden drop to idle reuses the previous latched value
	assign glitch = (latched <= `IDLE_LEVEL) && (prev_latched > `IDLE_LEVEL);

	// Three linear segments
	assign deb_w = `OPS_W'(debounced);

	always_comb begin
		if (debounced < `MID_LOW)
			scale_val = deb_w << 1;
		else if (debounced > `MID_HIGH)
			scale_val = (deb_w << 1) - SCALE_HIGH_OFS;
		else
			scale_val = (deb_w >> 1) + SCALE_MID_OFS;
	end

	// Limit the change since the previous output
	assign prev_w   = `OPS_W'(prev_out);
	assign rise_cap = prev_w + STEP;
	assign fall_val = prev_w - STEP;

	always_comb begin
		if (scaled < IDLE_W)
			limit_val = '0;
		else if (scaled > rise_cap)
			limit_val = (rise_cap > MAX_W) ? MAX_W : rise_cap;
		else if (prev_w > scaled + STEP)
			limit_val = (fall_val < IDLE_W) ? '0 : fall_val;
		else
			limit_val = (scaled > MAX_W) ? MAX_W : scaled;
	end

	// Starts are only taken while idle
	always_comb begin
		case (state)
			WAITING:  next_state = start ? DEGLITCH : WAITING;
			DEGLITCH: next_state = SCALE;
			SCALE:    next_state = LIMIT;
			LIMIT:    next_state = ASSIGN;
			ASSIGN:   next_state = COMPLETE;
			default:  next_state = WAITING;
		endcase
	end

	// Stage datapath
	always_ff @(posedge us_clk) begin
		case (state)
			WAITING: begin
				if (start)
					latched <= clamp_cmd;
			end
			DEGLITCH: debounced <= glitch ? prev_latched : latched;
			SCALE:    scaled <= scale_val;
			LIMIT:    limited <= limit_val;
			default:  limited <= limited;
		endcase
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state        <= WAITING;
			active       <= 1'b0;
			complete     <= 1'b0;
			throttle_out <= '0;
			prev_latched <= '0;
			prev_out     <= '0;
		end else begin
			state    <= next_state;
			active   <= (state == DEGLITCH) || (state == SCALE) || (state == LIMIT);
			complete <= (state == ASSIGN);
			if (state == DEGLITCH)
				prev_latched <= latched;
			// Bypass passes the clamped command straight through
			if (state == ASSIGN)
				throttle_out <= cfg.cond_enable ? limited[`THR_W-1:0] : latched;
			if (state == COMPLETE)
				prev_out <= throttle_out;
		end
	end

endmodule

/* logic/pulse_frame_gen.sv */
// Frame counter driving the motor pulse and the frame-start strobe
`include "throttle_macros.svh"

module pulse_frame_gen import throttle_pkg::*; (
	input  logic              us_clk,
	input  logic              resetn,
	input  throttle_cfg_t     cfg,
	input  logic [`THR_W-1:0] throttle,
	input  logic              complete,
	output logic              frame_start,
	output logic              pulse
);

	logic [`FRAME_W-1:0] cnt;
	logic [`FRAME_W-1:0] cnt_nxt;
	logic [`FRAME_W-1:0] frame_len;
	logic [`FRAME_W-1:0] high_ticks;
	logic [`THR_W-1:0]   pending_w;
	logic [`THR_W-1:0]   active_w;
	logic [`THR_W-1:0]   width_nxt;
	logic                wrap;
	logic                started;

	assign wrap    = (cnt == frame_len - 1'b1);
	assign cnt_nxt = wrap ? '0 : cnt + 1'b1;

	// New width applies from the frame start on
	assign width_nxt  = wrap ? pending_w : active_w;
	assign high_ticks = `FRAME_W'(`MIN_PULSE_TICKS) + `FRAME_W'(width_nxt);

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			cnt         <= '0;
			frame_len   <= `FRAME_W'(`FRAME_RESET_TICKS);
			pending_w   <= '0;
			active_w    <= '0;
			started     <= 1'b0;
			frame_start <= 1'b0;
			pulse       <= 1'b0;
		end else begin
			cnt         <= cnt_nxt;
			frame_start <= wrap;
			// Pulse stays low until the first full frame
			pulse       <= (started || wrap) && (cnt_nxt < high_ticks);
			if (complete)
				pending_w <= throttle;
			if (wrap) begin
				frame_len <= cfg.frame_ticks;
				active_w  <= pending_w;
				started   <= 1'b1;
			end
		end
	end

endmodule

/* logic/throttle_path_top.sv */
// Throttle path top level with registers, conditioner, frame generator and frame count
`include "throttle_macros.svh"

module throttle_path_top import throttle_pkg::*; (
	input  logic              us_clk,
	input  logic              resetn,
	input  apb_req_t          apb,
	output logic [15:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	output logic              pulse,
	output logic [`THR_W-1:0] throttle_out,
	output logic              complete
);

	throttle_cfg_t    cfg;
	throttle_status_t status;
	logic             frame_start;
	logic             active;
	logic [7:0]       frames;

	// Completed updates, wraps at 256
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			frames <= '0;
		else if (complete)
			frames <= frames + 8'd1;
	end

	assign status = '{value: throttle_out, busy: active, frames: frames};

	throttle_regs u_regs (
		.us_clk  (us_clk),
		.resetn  (resetn),
		.apb     (apb),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr),
		.status  (status),
		.cfg     (cfg)
	);

	throttle_controller u_ctrl (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.cfg          (cfg),
		.start        (frame_start),
		.throttle_out (throttle_out),
		.active       (active),
		.complete     (complete)
	);

	pulse_frame_gen u_frame (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.cfg         (cfg),
		.throttle    (throttle_out),
		.complete    (complete),
		.frame_start (frame_start),
		.pulse       (pulse)
	);

endmodule

/* dv/tb_clock.sv */
// Testbench clock and reset generator for us_clk and resetn
module tb_clock (
	output logic us_clk,
	output logic resetn
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 4;

	// 10 ns period
	initial begin
		us_clk = 1'b0;
		forever #5 us_clk = ~us_clk;
	end

	initial begin
		resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge us_clk);
		resetn <= 1'b1;
	end

endmodule

/* dv/throttle_path_chk.sv */
// Bound checker with conditioning reference model, register shadow and assertions
`include "throttle_macros.svh"

module throttle_path_chk import throttle_pkg::*; (
	input logic              us_clk,
	input logic              resetn,
	input apb_req_t          apb,
	input logic [15:0]       prdata,
	input logic              pready,
	input logic              pslverr,
	input logic              pulse,
	input logic [`THR_W-1:0] throttle_out,
	input logic              complete,
	input logic              frame_start,
	input logic              active
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// Shadow of the software registers
	logic                sh_en;
	logic                en_d;
	logic [`THR_W-1:0]   sh_cmd;
	logic [`FRAME_W-1:0] sh_frame;
	logic [`FRAME_W-1:0] frame_d;
	logic                access;
	logic                err_exp;
	logic [15:0]         rd_exp;
	logic [7:0]          frames_m;
	logic [3:0]          fs_hist;
	logic                busy_m;

	// Reference model state
	logic [`THR_W-1:0] cmd_cap;
	logic [`THR_W-1:0] prev_lat_m;
	logic [`THR_W-1:0] prev_out_m;
	logic [`THR_W-1:0] lat_m;
	logic [`THR_W-1:0] deb_m;
	logic [`THR_W-1:0] exp_out;
	logic [`THR_W-1:0] pend_m;
	logic [`THR_W-1:0] act_m;
	int                scl_m;
	int                lim_m;
	int                prev_i;
	int                hi_cnt;
	int                fcnt;
	int                len_m;

	assign access  = apb.psel && apb.penable;
	assign err_exp = !(apb.paddr inside {CTRL, CMD, FRAME, STATUS}) ||
		(apb.pwrite && ((apb.paddr == STATUS) ||
		((apb.paddr == FRAME) && (apb.pwdata < `FRAME_MIN_TICKS))));

	// Controller busy for the three stage cycles after the start edge
	assign busy_m = |fs_hist[3:1];

	always_comb begin
		case (apb.paddr)
			CTRL:    rd_exp = {15'd0, sh_en};
			CMD:     rd_exp = {8'd0, sh_cmd};
			FRAME:   rd_exp = sh_frame;
			STATUS:  rd_exp = {frames_m[6:0], busy_m, prev_out_m};
			default: rd_exp = '0;
		endcase
	end

	// Clamp, de-glitch, three segments, then the per-frame step limit
	always_comb begin
		if (cmd_cap < `IDLE_LEVEL)
			lat_m = '0;
		else if (cmd_cap > `MAX_LEVEL)
			lat_m = `THR_W'(`MAX_LEVEL);
		else
			lat_m = cmd_cap;
		deb_m = (lat_m <= `IDLE_LEVEL && prev_lat_m > `IDLE_LEVEL) ? prev_lat_m : lat_m;
		if (deb_m < `MID_LOW)
			scl_m = 2 * int'(deb_m);
		else if (deb_m > `MID_HIGH)
			scl_m = 2 * int'(deb_m) - 252;
		else
			scl_m = int'(deb_m) / 2 + 61;
		prev_i = int'(prev_out_m);
		if (scl_m < `IDLE_LEVEL)
			lim_m = 0;
		else if (scl_m > prev_i + `CHANGE_LIMIT)
			lim_m = (prev_i + `CHANGE_LIMIT > `MAX_LEVEL) ? `MAX_LEVEL : prev_i + `CHANGE_LIMIT;
		else if (scl_m < prev_i - `CHANGE_LIMIT)
			lim_m = (prev_i - `CHANGE_LIMIT < `IDLE_LEVEL) ? 0 : prev_i - `CHANGE_LIMIT;
		else
			lim_m = (scl_m > `MAX_LEVEL) ? `MAX_LEVEL : scl_m;
		exp_out = en_d ? `THR_W'(lim_m) : lat_m;
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			sh_en      <= 1'b1;
			en_d       <= 1'b1;
			sh_cmd     <= '0;
			sh_frame   <= `FRAME_W'(`FRAME_RESET_TICKS);
			frame_d    <= `FRAME_W'(`FRAME_RESET_TICKS);
			frames_m   <= '0;
			fs_hist    <= '0;
			cmd_cap    <= '0;
			prev_lat_m <= '0;
			prev_out_m <= '0;
			pend_m     <= '0;
			act_m      <= '0;
			hi_cnt     <= 0;
			fcnt       <= 0;
			len_m      <= `FRAME_RESET_TICKS;
		end else begin
			frame_d <= sh_frame;
			en_d    <= sh_en;
			fs_hist <= {fs_hist[2:0], frame_start};
			if (access && apb.pwrite && !err_exp) begin
				case (apb.paddr)
					CTRL:    sh_en <= apb.pwdata[0];
					CMD:     sh_cmd <= apb.pwdata[`THR_W-1:0];
					FRAME:   sh_frame <= apb.pwdata;
					default: sh_en <= sh_en;
				endcase
			end
			// Frame start latches the command and the next frame length
			if (frame_start) begin
				cmd_cap <= sh_cmd;
				len_m   <= int'(frame_d);
				act_m   <= pend_m;
			end
			if (complete) begin
				prev_lat_m <= lat_m;
				prev_out_m <= exp_out;
				pend_m     <= exp_out;
				frames_m   <= frames_m + 8'd1;
			end
			fcnt   <= frame_start ? 1 : fcnt + 1;
			hi_cnt <= frame_start ? 1 : (pulse ? hi_cnt + 1 : hi_cnt);
		end
	end

	assert property (@(posedge us_clk) $rose(resetn) |-> !pulse && !complete && throttle_out == '0)
		else begin
			$error("MISMATCH at %0t: outputs not idle after reset", $time);
			fail_count++;
		end

	assert property (@(posedge us_clk) disable iff (!resetn)
		complete |-> $past(frame_start, 5) && $past(active) && $past(active, 3) && !$past(complete))
		else begin
			$error("Update at %0t was not a single cycle four edges after frame start", $time);
			fail_count++;
		end

	assert property (@(posedge us_clk) disable iff (!resetn) complete |-> throttle_out == exp_out)
		else begin
			$error("MISMATCH at %0t: throttle_out %0d, expected %0d",
				$time, $sampled(throttle_out), exp_out);
			fail_count++;
		end

	assert property (@(posedge us_clk) disable iff (!resetn)
		$fell(pulse) |-> hi_cnt == `MIN_PULSE_TICKS + int'(act_m))
		else begin
			$error("MISMATCH at %0t: pulse high for %0d cycles, expected %0d",
				$time, hi_cnt, `MIN_PULSE_TICKS + int'(act_m));
			fail_count++;
		end

	assert property (@(posedge us_clk) disable iff (!resetn) frame_start |-> fcnt == len_m)
		else begin
			$error("MISMATCH at %0t: frame of %0d cycles, expected %0d", $time, fcnt, len_m);
			fail_count++;
		end

	assert property (@(posedge us_clk) disable iff (!resetn)
		access && !apb.pwrite |-> prdata == rd_exp)
		else begin
			$error("MISMATCH at %0t: read of address %0d gave %h, expected %h",
				$time, apb.paddr, $sampled(prdata), rd_exp);
			fail_count++;
		end

	assert property (@(posedge us_clk) disable iff (!resetn)
		access |-> pslverr == err_exp && pready)
		else begin
			$error("MISMATCH at %0t: pslverr %0b at address %0d, expected %0b",
				$time, $sampled(pslverr), apb.paddr, err_exp);
			fail_count++;
		end

endmodule

/* dv/throttle_path_tb.sv */
// Throttle path testbench with APB stimulus, LCG commands, watchdog and error summary
`include "throttle_macros.svh"

module throttle_path_tb import throttle_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_FRAMES   = 30;
	localparam int FRAME_CYCLES = `FRAME_RESET_TICKS;
	localparam int WAIT_CYCLES  = 2 * FRAME_CYCLES;
	// Room for twice the expected frames plus the APB traffic
	localparam int TIMEOUT_CYCLES = 2 * NUM_FRAMES * FRAME_CYCLES + 2000;
	localparam logic [7:0] FIXED_CMDS [6] = '{8'd5, 8'd255, 8'd30, 8'd120, 8'd230, 8'd0};

	logic              us_clk;
	logic              resetn;
	apb_req_t          apb;
	logic [15:0]       prdata;
	logic              pready;
	logic              pslverr;
	logic              pulse;
	logic [`THR_W-1:0] throttle_out;
	logic              complete;
	logic [31:0]       lcg_state;
	int                tb_errors = 0;
	int                frame_count = 0;
	int                cycle_count = 0;

	tb_clock u_clock (
		.us_clk (us_clk),
		.resetn (resetn)
	);

	throttle_path_top uut (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.apb          (apb),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.pulse        (pulse),
		.throttle_out (throttle_out),
		.complete     (complete)
	);

	bind throttle_path_top throttle_path_chk chk (
		.us_clk(us_clk), .resetn(resetn), .apb(apb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .pulse(pulse), .throttle_out(throttle_out),
		.complete(complete), .frame_start(frame_start), .active(active)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Setup cycle, then one access cycle
	task automatic apb_transfer(input logic write, input logic [`APB_AW-1:0] addr,
			input logic [15:0] data);
		@(posedge us_clk);
		apb.paddr   <= addr;
		apb.pwrite  <= write;
		apb.pwdata  <= data;
		apb.psel    <= 1'b1;
		apb.penable <= 1'b0;
		@(posedge us_clk);
		apb.penable <= 1'b1;
		@(posedge us_clk);
		apb.psel    <= 1'b0;
		apb.penable <= 1'b0;
	endtask

	task automatic wait_for_update();
		int n;
		n = 0;
		@(posedge us_clk);
		while (!complete && n < WAIT_CYCLES) begin
			@(posedge us_clk);
			n++;
		end
		if (!complete) begin
			$display("ERROR: no throttle update within %0d cycles at %0t", WAIT_CYCLES, $time);
			tb_errors++;
		end
		frame_count++;
	endtask

	// One frame per command, CMD read back, STATUS read mid-frame
	task automatic apply_command(input logic [7:0] cmd);
		apb_transfer(1'b1, CMD, {8'd0, cmd});
		apb_transfer(1'b0, CMD, '0);
		wait_for_update();
		apb_transfer(1'b0, STATUS, '0);
	endtask

	initial begin
		apb       = '0;
		lcg_state = 32'd23316;
		@(posedge resetn);
		// Reset values and refused accesses
		apb_transfer(1'b0, CTRL, '0);
		apb_transfer(1'b0, CMD, '0);
		apb_transfer(1'b0, FRAME, '0);
		apb_transfer(1'b0, 4'd2, '0);
		apb_transfer(1'b1, STATUS, 16'h00ff);
		apb_transfer(1'b1, FRAME, 16'd100);
		apb_transfer(1'b0, FRAME, '0);
		apb_transfer(1'b1, FRAME, 16'd280);
		apb_transfer(1'b0, FRAME, '0);
		for (int i = 0; i < 6; i++)
			apply_command(FIXED_CMDS[i]);
		// Settle at 120, then a single idle frame
		repeat (7) apply_command(8'd120);
		apply_command(8'd0);
		// Bypass mode
		apb_transfer(1'b1, CTRL, 16'd0);
		apb_transfer(1'b0, CTRL, '0);
		apply_command(8'd5);
		apply_command(8'd255);
		apply_command(8'd120);
		apb_transfer(1'b1, CTRL, 16'd1);
		apb_transfer(1'b1, FRAME, 16'd300);
		apb_transfer(1'b0, FRAME, '0);
		while (frame_count < NUM_FRAMES) begin
			lcg_state = lcg_next(lcg_state);
			apply_command(lcg_state[23:16]);
		end
		repeat (FRAME_CYCLES) @(posedge us_clk);
		$display("Errors: %0d assertion, %0d testbench", uut.chk.fail_count, tb_errors);
		if (uut.chk.fail_count == 0 && tb_errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog on the whole run
	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge us_clk);
			cycle_count++;
		end
		$display("ERROR: timeout after %0d cycles, the run did not finish", cycle_count);
		$display("Regression failed");
		$finish;
	end

endmodule

/* throttle_path_top.f */
+incdir+logic
logic/throttle_pkg.sv
logic/throttle_regs.sv
logic/throttle_controller.sv
logic/pulse_frame_gen.sv
logic/throttle_path_top.sv
dv/tb_clock.sv
dv/throttle_path_chk.sv
dv/throttle_path_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TB_TOP     := throttle_path_tb
RTL_TOP    := throttle_path_top
FILELIST   := throttle_path_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/1ps
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not report a pass" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
